// File: logic/bus_pkg.sv
// Wishbone classic request and response struct types
`default_nettype none
`include "cache_defines.svh"

package bus_pkg;

    localparam int SEL_WIDTH = `DATA_WIDTH / 8; // one select bit per byte.

    // master to slave, held steady until ack.
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`ADDR_WIDTH-1:0] adr;
        logic [SEL_WIDTH-1:0]   sel;
        logic [`DATA_WIDTH-1:0] dat;
    } wb_req_t;

    // slave to master, read data valid with ack.
    typedef struct packed {
        logic                   ack;
        logic [`DATA_WIDTH-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: logic/cache_defines.svh
// bus address width, bus data width and cache index width macros
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// byte address on every bus.
`define ADDR_WIDTH 32

// one word per bus beat and per cache line.
`define DATA_WIDTH 32

// line index width, 16 lines per cache.
`define CACHE_INDEX_BITS 4

`endif

// File: logic/cache_pkg.sv
// cache address union and cache line struct types
`default_nettype none
`include "cache_defines.svh"

package cache_pkg;

    localparam int OFFSET_BITS = 2; // byte within the word.
    localparam int TAG_BITS    = `ADDR_WIDTH - `CACHE_INDEX_BITS - OFFSET_BITS;

    typedef struct packed {
        logic [TAG_BITS-1:0]          tag;
        logic [`CACHE_INDEX_BITS-1:0] index;
        logic [OFFSET_BITS-1:0]       offset;
    } cache_addr_t;

    // same bits, seen as a bus address or as cache fields.
    typedef union packed {
        logic [`ADDR_WIDTH-1:0] raw;
        cache_addr_t            fields;
    } cache_addr_u;

    typedef struct packed {
        logic                   valid;
        logic [TAG_BITS-1:0]    tag;
        logic [`DATA_WIDTH-1:0] data;
    } cache_line_t;

endpackage

`default_nettype wire

// File: logic/dcache.sv
// direct-mapped write-through data cache with byte-merging write hits
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module dcache (
    input  logic             CLK,
    input  logic             rst,
    input  logic             invalidate,
    input  bus_pkg::wb_req_t proc_req,
    output bus_pkg::wb_rsp_t proc_rsp,
    output bus_pkg::wb_req_t mem_req,
    input  bus_pkg::wb_rsp_t mem_rsp
);
    localparam int NUM_LINES = 1 << `CACHE_INDEX_BITS;

    typedef enum logic [1:0] {
        IDLE,
        REPLY,
        FILL,
        WRITE
    } state_t;

    state_t                 state;
    cache_pkg::cache_line_t lines [NUM_LINES];
    cache_pkg::cache_line_t cur_line;
    cache_pkg::cache_line_t fill_line;
    cache_pkg::cache_addr_u req_addr;
    cache_pkg::cache_addr_u line_addr;
    logic [`DATA_WIDTH-1:0] rdata;
    logic [`DATA_WIDTH-1:0] merged;
    logic                   req_valid;
    logic                   hit;
    logic                   mem_busy;

    assign req_addr.raw = proc_req.adr;
    assign cur_line     = lines[req_addr.fields.index];
    assign req_valid    = proc_req.cyc && proc_req.stb;
    assign hit          = cur_line.valid && (cur_line.tag == req_addr.fields.tag);
    assign mem_busy     = (state == FILL) || (state == WRITE);

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        if (proc_req.we) begin
                            state <= WRITE; // every write goes through.
                        end else begin
                            state <= hit ? REPLY : FILL;
                        end
                    end
                end
                FILL, WRITE: begin
                    if (mem_rsp.ack) begin
                        state <= REPLY;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == IDLE && req_valid && !proc_req.we && hit) begin
            rdata <= cur_line.data;
        end else if (state == FILL && mem_rsp.ack) begin
            rdata <= mem_rsp.dat;
        end
    end

    // written bytes laid over the cached word.
    always_comb begin
        merged = cur_line.data;
        for (int b = 0; b < bus_pkg::SEL_WIDTH; b++) begin
            if (proc_req.sel[b]) begin
                merged[8*b +: 8] = proc_req.dat[8*b +: 8];
            end
        end
    end

    always_comb begin
        fill_line.valid = 1'b1;
        fill_line.tag   = req_addr.fields.tag;
        fill_line.data  = mem_rsp.dat;
    end

    always_ff @(posedge CLK) begin
        if (rst || invalidate) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (state == FILL && mem_rsp.ack) begin
            lines[req_addr.fields.index] <= fill_line;
        end else if (state == WRITE && mem_rsp.ack && hit) begin
            lines[req_addr.fields.index].data <= merged; // write miss: no allocate.
        end
    end

    always_comb begin
        line_addr               = req_addr;
        line_addr.fields.offset = '0;
        mem_req.cyc             = mem_busy;
        mem_req.stb             = mem_busy;
        mem_req.we              = (state == WRITE);
        mem_req.adr             = line_addr.raw;
        mem_req.sel             = (state == WRITE) ? proc_req.sel : '1;
        mem_req.dat             = proc_req.dat;
    end

    always_comb begin
        proc_rsp.ack = (state == REPLY);
        proc_rsp.dat = rdata;
    end

endmodule

`default_nettype wire

// File: logic/icache.sv
// read-only direct-mapped instruction cache with miss fill
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module icache (
    input  logic             CLK,
    input  logic             rst,
    input  logic             invalidate,
    input  bus_pkg::wb_req_t proc_req,
    output bus_pkg::wb_rsp_t proc_rsp,
    output bus_pkg::wb_req_t mem_req,
    input  bus_pkg::wb_rsp_t mem_rsp
);
    localparam int NUM_LINES = 1 << `CACHE_INDEX_BITS;

    typedef enum logic [1:0] {
        IDLE,
        REPLY,
        FILL
    } state_t;

    state_t                 state;
    cache_pkg::cache_line_t lines [NUM_LINES];
    cache_pkg::cache_line_t cur_line;
    cache_pkg::cache_line_t fill_line;
    cache_pkg::cache_addr_u req_addr;
    cache_pkg::cache_addr_u fill_addr;
    logic [`DATA_WIDTH-1:0] rdata;
    logic                   req_valid;
    logic                   hit;

    assign req_addr.raw = proc_req.adr;
    assign cur_line     = lines[req_addr.fields.index];
    assign req_valid    = proc_req.cyc && proc_req.stb; // we is ignored.
    assign hit          = cur_line.valid && (cur_line.tag == req_addr.fields.tag);

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        state <= hit ? REPLY : FILL;
                    end
                end
                FILL: begin
                    if (mem_rsp.ack) begin
                        state <= REPLY;
                    end
                end
                default: state <= IDLE; // reply lasts one cycle.
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == IDLE && req_valid && hit) begin
            rdata <= cur_line.data;
        end else if (state == FILL && mem_rsp.ack) begin
            rdata <= mem_rsp.dat;
        end
    end

    always_comb begin
        fill_line.valid = 1'b1;
        fill_line.tag   = req_addr.fields.tag;
        fill_line.data  = mem_rsp.dat;
    end

    // tag and data are only written on a fill.
    always_ff @(posedge CLK) begin
        if (rst || invalidate) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (state == FILL && mem_rsp.ack) begin
            lines[req_addr.fields.index] <= fill_line;
        end
    end

    always_comb begin
        fill_addr               = req_addr;
        fill_addr.fields.offset = '0; // whole word fetch.
        mem_req                 = '0;
        mem_req.cyc             = (state == FILL);
        mem_req.stb             = (state == FILL);
        mem_req.adr             = fill_addr.raw;
        mem_req.sel             = '1;
    end

    always_comb begin
        proc_rsp.ack = (state == REPLY);
        proc_rsp.dat = rdata;
    end

endmodule

`default_nettype wire

// File: logic/mem_arbiter.sv
// two-master to one-slave Wishbone arbiter, data cache first
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic             CLK,
    input  logic             rst,
    input  bus_pkg::wb_req_t icache_req,
    input  bus_pkg::wb_req_t dcache_req,
    output bus_pkg::wb_rsp_t icache_rsp,
    output bus_pkg::wb_rsp_t dcache_rsp,
    output bus_pkg::wb_req_t mem_req,
    input  bus_pkg::wb_rsp_t mem_rsp
);
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_INSTR,
        OWN_DATA
    } owner_t;

    owner_t owner;
    logic   i_want;
    logic   d_want;

    assign i_want = icache_req.cyc && icache_req.stb;
    assign d_want = dcache_req.cyc && dcache_req.stb;

    always_ff @(posedge CLK) begin
        if (rst) begin
            owner <= OWN_NONE;
        end else begin
            case (owner)
                OWN_NONE: begin
                    if (d_want) begin
                        owner <= OWN_DATA; // data wins a tie.
                    end else if (i_want) begin
                        owner <= OWN_INSTR;
                    end
                end
                default: begin
                    if (mem_rsp.ack) begin
                        owner <= OWN_NONE; // master drops cyc on this edge.
                    end
                end
            endcase
        end
    end

    always_comb begin
        case (owner)
            OWN_INSTR: mem_req = icache_req;
            OWN_DATA:  mem_req = dcache_req;
            default:   mem_req = '0;
        endcase
    end

    always_comb begin
        icache_rsp.ack = (owner == OWN_INSTR) && mem_rsp.ack;
        icache_rsp.dat = mem_rsp.dat;
        dcache_rsp.ack = (owner == OWN_DATA) && mem_rsp.ack;
        dcache_rsp.dat = mem_rsp.dat;
    end

endmodule

`default_nettype wire

// File: logic/separate_caches.sv
// split instruction and data caches sharing one memory bus
`timescale 1ns/1ps
`default_nettype none

module separate_caches (
    input  logic             CLK,
    input  logic             rst,
    input  logic             invalidate,
    input  bus_pkg::wb_req_t ibus_req,
    input  bus_pkg::wb_req_t dbus_req,
    output bus_pkg::wb_rsp_t ibus_rsp,
    output bus_pkg::wb_rsp_t dbus_rsp,
    output bus_pkg::wb_req_t mem_req,
    input  bus_pkg::wb_rsp_t mem_rsp
);
    bus_pkg::wb_req_t icache_mem_req;
    bus_pkg::wb_rsp_t icache_mem_rsp;
    bus_pkg::wb_req_t dcache_mem_req;
    bus_pkg::wb_rsp_t dcache_mem_rsp;

    icache icache_i (
        .CLK        (CLK),
        .rst        (rst),
        .invalidate (invalidate), // clears both caches together.
        .proc_req   (ibus_req),
        .proc_rsp   (ibus_rsp),
        .mem_req    (icache_mem_req),
        .mem_rsp    (icache_mem_rsp)
    );

    dcache dcache_i (
        .CLK        (CLK),
        .rst        (rst),
        .invalidate (invalidate),
        .proc_req   (dbus_req),
        .proc_rsp   (dbus_rsp),
        .mem_req    (dcache_mem_req),
        .mem_rsp    (dcache_mem_rsp)
    );

    mem_arbiter mem_arbiter_i (
        .CLK        (CLK),
        .rst        (rst),
        .icache_req (icache_mem_req),
        .dcache_req (dcache_mem_req),
        .icache_rsp (icache_mem_rsp),
        .dcache_rsp (dcache_mem_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# builds the cache testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_separate_caches \
    -f sources.f

out=$(./obj_dir/Vtb_separate_caches)
echo "$out"

# the run passes only if the pass message stands on a line of its own
echo "$out" | grep -qx "NO ERRORS"

// File: sources.f
+incdir+logic
logic/bus_pkg.sv
logic/cache_pkg.sv
logic/icache.sv
logic/dcache.sv
logic/mem_arbiter.sv
logic/separate_caches.sv
test/wb_memory_model.sv
test/tb_separate_caches.sv

// File: test/tb_separate_caches.sv
// testbench for the split caches: stimulus, reference model, compare and report
`timescale 1ns/1ps
`default_nettype none

module tb_separate_caches;

    logic             CLK;
    logic             rst;
    logic             invalidate;
    bus_pkg::wb_req_t ibus_req;
    bus_pkg::wb_req_t dbus_req;
    bus_pkg::wb_rsp_t ibus_rsp;
    bus_pkg::wb_rsp_t dbus_rsp;
    bus_pkg::wb_req_t mem_req;
    bus_pkg::wb_rsp_t mem_rsp;

    logic [15:0] lfsr;
    logic [31:0] shadow_data [256];
    logic [3:0]  shadow_mask [256]; // bytes written so far.
    logic [31:0] i_expect [$];
    logic [31:0] d_expect [$];
    string       test_name;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;

    separate_caches separate_caches_i (
        .CLK        (CLK),
        .rst        (rst),
        .invalidate (invalidate),
        .ibus_req   (ibus_req),
        .dbus_req   (dbus_req),
        .ibus_rsp   (ibus_rsp),
        .dbus_rsp   (dbus_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    wb_memory_model mem_model_i (
        .CLK (CLK),
        .rst (rst),
        .req (mem_req),
        .rsp (mem_rsp)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // initial memory word with every recorded write laid over it.
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [7:0]  idx;
        logic [31:0] w;
        idx = addr[9:2];
        w   = {24'd0, idx} * 32'h01010101 ^ 32'hA5A5A5A5;
        for (int b = 0; b < 4; b++) begin
            if (shadow_mask[idx][b]) begin
                w[8*b +: 8] = shadow_data[idx][8*b +: 8];
            end
        end
        return w;
    endfunction

    task automatic record_write(input logic [31:0] addr, input logic [3:0] sel,
                                input logic [31:0] dat);
        logic [7:0] idx;
        idx = addr[9:2];
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                shadow_data[idx][8*b +: 8] = dat[8*b +: 8];
            end
        end
        shadow_mask[idx] = shadow_mask[idx] | sel;
    endtask

    task automatic check_word(input string port, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("** Error: %s, %s read: expected %h, actual %h", test_name, port, exp, act);
        end
    endtask

    // read data compared on the edge where the master sees ack.
    always @(posedge CLK) begin
        if (ibus_rsp.ack) begin
            if (i_expect.size() == 0) begin
                errors++;
                $display("unexpected ack on the instruction port in %s", test_name);
            end else begin
                check_word("instruction", i_expect.pop_front(), ibus_rsp.dat);
            end
        end
        if (dbus_rsp.ack && !dbus_req.we) begin
            if (d_expect.size() == 0) begin
                errors++;
                $display("unexpected ack on the data port in %s", test_name);
            end else begin
                check_word("data", d_expect.pop_front(), dbus_rsp.dat);
            end
        end
    end

    task automatic abort_run(input string what);
        $display("%s in %s", what, test_name);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic transfer(input logic data_port, input logic we, input logic [31:0] addr,
                            input logic [3:0] sel, input logic [31:0] wdata,
                            output int cycles);
        bus_pkg::wb_req_t req;
        logic             acked;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = addr;
        req.sel = sel;
        req.dat = wdata;
        cycles  = 0;
        acked   = 1'b0;
        @(posedge CLK);
        #1;
        if (data_port) dbus_req = req;
        else ibus_req = req;
        while (!acked && cycles < 200) begin
            @(posedge CLK);
            cycles++;
            acked = data_port ? dbus_rsp.ack : ibus_rsp.ack;
        end
        if (!acked) begin
            abort_run(data_port ? "data port never acknowledged"
                                : "instruction port never acknowledged");
        end else begin
            #1;
            if (data_port) dbus_req = '0;
            else ibus_req = '0;
        end
    endtask

    task automatic instr_read(input logic [31:0] addr, input logic [31:0] exp,
                              output int cycles);
        i_expect.push_back(exp);
        transfer(1'b0, 1'b0, addr, 4'hF, '0, cycles);
    endtask

    task automatic data_read(input logic [31:0] addr);
        int cycles;
        d_expect.push_back(expected_word(addr));
        transfer(1'b1, 1'b0, addr, 4'hF, '0, cycles);
    endtask

    task automatic data_write(input logic [31:0] addr, input logic [3:0] sel,
                              input logic [31:0] dat);
        int cycles;
        record_write(addr, sel, dat);
        transfer(1'b1, 1'b1, addr, sel, dat, cycles);
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("%s: passed", test_name);
        end else begin
            tests_failed++;
            $display("%s: failed, %0d mismatches", test_name, errors - errors_at_start);
        end
    endtask

    initial begin
        int          lat;
        logic [31:0] ia;
        logic [31:0] da;
        logic [31:0] dd;
        logic [31:0] old;
        logic [3:0]  dsel;
        logic        kind;
        ibus_req     = '0;
        dbus_req     = '0;
        invalidate   = 1'b0;
        rst          = 1'b1;
        lfsr         = 16'd13;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 256; i++) begin
            shadow_mask[i] = 4'h0;
            shadow_data[i] = '0;
        end
        repeat (4) @(posedge CLK);
        #1 rst = 1'b0;

        start_test("instruction miss then hit");
        instr_read(32'h100, expected_word(32'h100), lat);
        instr_read(32'h100, expected_word(32'h100), lat);
        if (lat != 2) begin
            errors++;
            $display("** Error: %s, hit latency: expected 2, actual %0d", test_name, lat);
        end
        finish_test();

        start_test("partial data writes");
        data_read(32'h040); // line cached before the write.
        data_write(32'h040, 4'b0110, rand_bits(32));
        data_read(32'h040);
        data_write(32'h080, 4'b1001, rand_bits(32)); // uncached, refetched on read.
        data_read(32'h080);
        finish_test();

        start_test("stale instruction line and invalidate");
        old = expected_word(32'h200);
        instr_read(32'h200, old, lat);
        data_write(32'h200, 4'hF, rand_bits(32));
        instr_read(32'h200, old, lat); // icache still holds the old word.
        @(posedge CLK);
        #1 invalidate = 1'b1;
        @(posedge CLK);
        #1 invalidate = 1'b0;
        instr_read(32'h200, expected_word(32'h200), lat);
        finish_test();

        start_test("simultaneous misses");
        fork
            instr_read(32'h380, expected_word(32'h380), lat);
            data_read(32'h0C0);
        join
        finish_test();

        // instruction region 0x300 to 0x3FC is never written.
        start_test("random mixed transfers");
        for (int n = 0; n < 30; n++) begin
            ia   = 32'h300 | (rand_bits(6) << 2);
            kind = 1'(rand_bits(1));
            da   = rand_bits(6) << 2;
            dsel = 4'(rand_bits(4));
            dd   = rand_bits(32);
            fork
                instr_read(ia, expected_word(ia), lat);
                if (kind) data_write(da, dsel, dd);
                else data_read(da);
            join
        end
        finish_test();

        $display("%0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/wb_memory_model.sv
// Wishbone classic slave memory of 256 words with random wait states
`timescale 1ns/1ps
`default_nettype none

module wb_memory_model (
    input  logic             CLK,
    input  logic             rst,
    input  bus_pkg::wb_req_t req,
    output bus_pkg::wb_rsp_t rsp
);
    logic [31:0] mem [256];
    logic [15:0] lfsr;
    logic [1:0]  wait_cnt;
    logic        busy;
    logic [7:0]  idx;

    assign idx = req.adr[9:2]; // upper address bits ignored.

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    always @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= 32'(i) * 32'h01010101 ^ 32'hA5A5A5A5;
            end
            lfsr     = 16'd13;
            rsp      <= '0;
            busy     <= 1'b0;
            wait_cnt <= '0;
        end else if (rsp.ack) begin
            rsp.ack <= 1'b0; // ack lasts one cycle.
        end else if (req.cyc && req.stb) begin
            if (!busy) begin
                busy     <= 1'b1;
                wait_cnt <= 2'(rand_bits(2)); // 0 to 3 wait states.
            end else if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                busy    <= 1'b0;
                rsp.ack <= 1'b1;
                rsp.dat <= mem[idx];
                for (int b = 0; b < 4; b++) begin
                    if (req.we && req.sel[b]) begin
                        mem[idx][8*b +: 8] <= req.dat[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire
